// ==== rtl/cell_arbiter.sv ====
module cell_arbiter #(
  parameter int N_CELLS = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     chain_end,
  input  logic [N_CELLS-1:0]       want,
  input  logic [N_CELLS-1:0]       halted,
  input  cpu_cluster_pkg::mem_dn_t reply,
  output logic                     chain_start,
  output logic [N_CELLS-1:0]       grant,
  output logic                     halt_q
);
  import cpu_cluster_pkg::*;

  localparam int IDX_W = (N_CELLS > 1) ? $clog2(N_CELLS) : 1;

  logic               launched;
  logic               chain_seen;
  logic [IDX_W-1:0]   last_idx;
  logic [IDX_W-1:0]   pick_idx;
  logic               pick_valid;
  logic [N_CELLS-1:0] grant_nxt;
  logic               done;

  assign done = reply.read_dn | reply.write_dn;

  // round-robin search, starting after the last granted cell
  always_comb begin
    int cand;
    pick_valid = 1'b0;
    pick_idx   = '0;
    grant_nxt  = '0;
    for (int k = 1; k <= N_CELLS; k++) begin
      cand = (int'(last_idx) + k) % N_CELLS;
      if (!pick_valid && want[cand]) begin
        pick_valid = 1'b1;
        pick_idx   = IDX_W'(cand);
      end
    end
    grant_nxt[pick_idx] = pick_valid;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      launched    <= 1'b0;
      chain_start <= 1'b0;
      chain_seen  <= 1'b0;
      grant       <= '0;
      last_idx    <= IDX_W'(N_CELLS - 1);
      halt_q      <= 1'b0;
    end else begin
      // single launch pulse for the reset chain
      launched    <= 1'b1;
      chain_start <= !launched;
      if (chain_end) begin
        chain_seen <= 1'b1;
      end
      // grant held until the reply, then dropped
      if (|grant) begin
        if (done) begin
          grant <= '0;
        end
      end else if (chain_seen && pick_valid) begin
        grant    <= grant_nxt;
        last_idx <= pick_idx;
      end
      // sticky cluster halt
      if (&halted) begin
        halt_q <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/cpu_block.sv ====
module cpu_block #(
  parameter int                     N_CELLS       = 4,
  parameter int                     OPS_PER_CELL  = 4,
  parameter int                     CELL_SPAN     = 16,
  parameter cpu_cluster_pkg::addr_t PROTECTED_TOP = 8'h08
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_cluster_pkg::data_t data_in,
  input  logic                   read_dn,
  input  logic                   write_dn,
  input  logic                   rw_halt_in,
  output cpu_cluster_pkg::addr_t addr_out,
  output cpu_cluster_pkg::data_t data_out,
  output logic                   read_q,
  output logic                   write_q,
  output logic                   rw_halt_out,
  output logic                   halt_q
);
  import cpu_cluster_pkg::*;

  // reset chain taps, chain[0] is the launch pulse
  logic [N_CELLS:0]   chain;
  logic               chain_start;
  logic               chain_end;
  logic [N_CELLS-1:0] want;
  logic [N_CELLS-1:0] halted;
  logic [N_CELLS-1:0] grant;
  mem_dn_t            reply;
  cell_bus_t          cell_bus [N_CELLS];
  // running OR of the cell buses
  cell_bus_t          bus_or   [N_CELLS];
  cell_bus_t          merged_bus;

  assign chain[0]   = chain_start;
  assign chain_end  = chain[N_CELLS];
  assign merged_bus = bus_or[N_CELLS-1];

  for (genvar i = 0; i < N_CELLS; i++) begin : g_cell
    cpu_cell #(
      .CELL_INDEX  (i),
      .CELL_SPAN   (CELL_SPAN),
      .OPS_PER_CELL(OPS_PER_CELL)
    ) i_cell (
      .clk      (clk),
      .rst_n    (rst_n),
      .chain_in (chain[i]),
      .granted  (grant[i]),
      .reply    (reply),
      .chain_out(chain[i+1]),
      .want     (want[i]),
      .bus      (cell_bus[i]),
      .halted   (halted[i])
    );

    // idle cells drive zero, so OR is the bus merge
    if (i == 0) begin : g_or_first
      assign bus_or[i] = cell_bus[i];
    end else begin : g_or_next
      assign bus_or[i] = cell_bus_t'(bus_or[i-1] | cell_bus[i]);
    end
  end

  cell_arbiter #(
    .N_CELLS(N_CELLS)
  ) i_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .chain_end  (chain_end),
    .want       (want),
    .halted     (halted),
    .reply      (reply),
    .chain_start(chain_start),
    .grant      (grant),
    .halt_q     (halt_q)
  );

  ext_mem_port #(
    .PROTECTED_TOP(PROTECTED_TOP)
  ) i_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .merged_bus (merged_bus),
    .data_in    (data_in),
    .read_dn    (read_dn),
    .write_dn   (write_dn),
    .rw_halt_in (rw_halt_in),
    .addr_out   (addr_out),
    .data_out   (data_out),
    .read_q     (read_q),
    .write_q    (write_q),
    .rw_halt_out(rw_halt_out),
    .reply      (reply)
  );

endmodule

// ==== rtl/cpu_cell.sv ====
module cpu_cell #(
  parameter int CELL_INDEX   = 0,
  parameter int CELL_SPAN    = 16,
  parameter int OPS_PER_CELL = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       chain_in,
  input  logic                       granted,
  input  cpu_cluster_pkg::mem_dn_t   reply,
  output logic                       chain_out,
  output logic                       want,
  output cpu_cluster_pkg::cell_bus_t bus,
  output logic                       halted
);
  import cpu_cluster_pkg::*;

  // word counter wide enough for OPS_PER_CELL words
  localparam int CNT_W = (OPS_PER_CELL > 1) ? $clog2(OPS_PER_CELL) : 1;
  // first address owned by this cell
  localparam addr_t BASE_ADDR = addr_t'(CELL_INDEX * CELL_SPAN);

  cell_state_e      state;
  logic [CNT_W-1:0] word_cnt;
  data_t            word_val;
  addr_t            word_addr;
  logic             last_word;
  logic             rd_done;
  logic             wr_done;

  // reply is broadcast, only the granted cell may consume it
  assign rd_done = granted & reply.read_dn;
  assign wr_done = granted & reply.write_dn;

  assign word_addr = BASE_ADDR + addr_t'(word_cnt);
  assign last_word = (word_cnt == CNT_W'(OPS_PER_CELL - 1));

  // sequencer and reset-chain stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= CELL_WAIT_CHAIN;
      word_cnt  <= '0;
      chain_out <= 1'b0;
    end else begin
      // chain pulse passes through once, one cycle late
      chain_out <= chain_in && (state == CELL_WAIT_CHAIN);
      case (state)
        CELL_WAIT_CHAIN: begin
          if (chain_in) begin
            state    <= CELL_READ;
            word_cnt <= '0;
          end
        end
        CELL_READ: begin
          if (rd_done) begin
            state <= CELL_WRITE;
          end
        end
        CELL_WRITE: begin
          if (wr_done) begin
            if (last_word) begin
              state <= CELL_HALTED;
            end else begin
              state    <= CELL_READ;
              word_cnt <= word_cnt + 1'b1;
            end
          end
        end
        default: begin
          // halted until the next reset
          state <= CELL_HALTED;
        end
      endcase
    end
  end

  // word read back from memory
  always_ff @(posedge clk) begin
    if (rd_done) begin
      word_val <= reply.data;
    end
  end

  // request stays up as a level across both phases
  assign want   = (state == CELL_READ) || (state == CELL_WRITE);
  assign halted = (state == CELL_HALTED);

  // drive the shared bus only under grant
  always_comb begin
    bus = '0;
    if (granted && want) begin
      bus.addr = word_addr;
      if (state == CELL_READ) begin
        bus.read_q = 1'b1;
      end else begin
        bus.data    = word_val + 1'b1;
        bus.write_q = 1'b1;
      end
    end
  end

endmodule

// ==== rtl/cpu_cluster_pkg.sv ====
package cpu_cluster_pkg;

  // address and data widths of the cluster bus
  localparam int ADDR_W = 8;
  localparam int DATA_W = 16;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // one cell's request toward the dispatcher
  // all zero while the cell holds no grant, so cells OR-merge
  typedef struct packed {
    addr_t addr;
    data_t data;
    logic  read_q;
    logic  write_q;
  } cell_bus_t;

  // dispatcher reply, broadcast to every cell
  // done flags pulse for exactly one cycle
  typedef struct packed {
    data_t data;
    logic  read_dn;
    logic  write_dn;
  } mem_dn_t;

  // cell sequencer
  typedef enum logic [1:0] {
    CELL_WAIT_CHAIN,
    CELL_READ,
    CELL_WRITE,
    CELL_HALTED
  } cell_state_e;

  // external memory port
  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_EXT_READ,
    PORT_EXT_WRITE,
    PORT_REPLY
  } port_state_e;

endpackage

// ==== rtl/ext_mem_port.sv ====
module ext_mem_port #(
  parameter cpu_cluster_pkg::addr_t PROTECTED_TOP = 8'h08
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  cpu_cluster_pkg::cell_bus_t merged_bus,
  input  cpu_cluster_pkg::data_t     data_in,
  input  logic                       read_dn,
  input  logic                       write_dn,
  input  logic                       rw_halt_in,
  output cpu_cluster_pkg::addr_t     addr_out,
  output cpu_cluster_pkg::data_t     data_out,
  output logic                       read_q,
  output logic                       write_q,
  output logic                       rw_halt_out,
  output cpu_cluster_pkg::mem_dn_t   reply
);
  import cpu_cluster_pkg::*;

  port_state_e state;
  // pending reply acknowledges a write
  logic        reply_wr;
  data_t       rd_data;
  logic        prot_hit;
  logic        start_ext;

  // write into the protected region, answered here
  assign prot_hit = merged_bus.write_q && (merged_bus.addr < PROTECTED_TOP);

  // new external access, blocked by hold-off
  assign start_ext = (state == PORT_IDLE) && !rw_halt_in && !prot_hit
                     && (merged_bus.read_q || merged_bus.write_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= PORT_IDLE;
      reply_wr <= 1'b0;
    end else begin
      case (state)
        PORT_IDLE: begin
          if (prot_hit) begin
            // swallowed, reply on the next cycle
            state    <= PORT_REPLY;
            reply_wr <= 1'b1;
          end else if (start_ext) begin
            state <= merged_bus.read_q ? PORT_EXT_READ : PORT_EXT_WRITE;
          end
        end
        PORT_EXT_READ: begin
          if (read_dn) begin
            state    <= PORT_REPLY;
            reply_wr <= 1'b0;
          end
        end
        PORT_EXT_WRITE: begin
          if (write_dn) begin
            state    <= PORT_REPLY;
            reply_wr <= 1'b1;
          end
        end
        default: begin
          state <= PORT_IDLE;
        end
      endcase
    end
  end

  // address and data held for the whole external access
  always_ff @(posedge clk) begin
    if (start_ext) begin
      addr_out <= merged_bus.addr;
      data_out <= merged_bus.data;
    end
    if ((state == PORT_EXT_READ) && read_dn) begin
      rd_data <= data_in;
    end
  end

  // request levels decode straight from the state flops
  assign read_q      = (state == PORT_EXT_READ);
  assign write_q     = (state == PORT_EXT_WRITE);
  assign rw_halt_out = read_q | write_q;

  // one-cycle reply toward the cells
  assign reply.data     = rd_data;
  assign reply.read_dn  = (state == PORT_REPLY) && !reply_wr;
  assign reply.write_dn = (state == PORT_REPLY) && reply_wr;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cpu_block testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log_file="sim.log"
fail_text="FAIL: see errors above"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cpu_block -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# raise the error limit so every failed assertion is counted
./obj_dir/sim_tb +verilator+error+limit+1000 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qF "$fail_text" "$log_file"; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished without failures"
exit 0

// ==== tb.f ====
rtl/cpu_cluster_pkg.sv
rtl/cpu_cell.sv
rtl/cell_arbiter.sv
rtl/ext_mem_port.sv
rtl/cpu_block.sv
verification/cpu_block_assertions.sv
verification/tb_cpu_block.sv

// ==== verification/cpu_block_assertions.sv ====
module cpu_block_assertions #(
  parameter int                     N_CELLS       = 4,
  parameter cpu_cluster_pkg::addr_t PROTECTED_TOP = 8'h08
) (
  input logic                   clk,
  input logic                   rst_n,
  input cpu_cluster_pkg::addr_t addr_out,
  input cpu_cluster_pkg::data_t data_out,
  input logic                   read_q,
  input logic                   write_q,
  input logic                   read_dn,
  input logic                   write_dn,
  input logic                   rw_halt_in,
  input logic                   rw_halt_out,
  input logic                   halt_q,
  input logic [N_CELLS-1:0]     grant,
  input logic                   chain_start,
  input logic                   chain_end
);
  import cpu_cluster_pkg::*;

  // memory fill used by the external responder
  localparam data_t FILL_KEY = 16'h5a5a;

  // failed checks so far, collected by the testbench
  int fail_cnt = 0;

  // fill word plus one, what a cell writes back
  function automatic data_t written_word(addr_t addr);
    return (data_t'(addr) ^ FILL_KEY) + data_t'(1);
  endfunction

  // port outputs quiet in the first cycle out of reset
  assert property (@(posedge clk)
    $rose(rst_n) |-> !read_q && !write_q && !halt_q && !rw_halt_out)
    else begin
      $error("port outputs not all low in the first cycle after reset");
      fail_cnt++;
    end

  // increment rule on every external write
  assert property (@(posedge clk) disable iff (!rst_n)
    write_q |-> data_out == written_word(addr_out))
    else begin
      $error("error: data_out 0x%h, expected 0x%h", data_out, written_word(addr_out));
      fail_cnt++;
    end

  // protected region never reaches the outside
  assert property (@(posedge clk) disable iff (!rst_n)
    write_q |-> addr_out >= PROTECTED_TOP)
    else begin
      $error("error: addr_out 0x%h, expected at least 0x%h", addr_out, PROTECTED_TOP);
      fail_cnt++;
    end

  // no new request while held off
  assert property (@(posedge clk) disable iff (!rst_n)
    ($rose(read_q) || $rose(write_q)) |-> !$past(rw_halt_in))
    else begin
      $error("external request started while rw_halt_in was high");
      fail_cnt++;
    end

  // requests are held levels up to their done pulse
  assert property (@(posedge clk) disable iff (!rst_n)
    (read_q && !read_dn) |=> read_q)
    else begin
      $error("read_q dropped before read_dn");
      fail_cnt++;
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    (write_q && !write_dn) |=> write_q)
    else begin
      $error("write_q dropped before write_dn");
      fail_cnt++;
    end

  // busy flag high exactly while an external request is outstanding
  assert property (@(posedge clk) disable iff (!rst_n)
    rw_halt_out == (read_q || write_q))
    else begin
      $error("error: rw_halt_out 0x%h, expected 0x%h", rw_halt_out, read_q || write_q);
      fail_cnt++;
    end

  // one owner of the shared bus
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
    else begin
      $error("error: grant 0x%h, expected at most one bit set", grant);
      fail_cnt++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) !(read_q && write_q))
    else begin
      $error("read_q and write_q high together");
      fail_cnt++;
    end

  // chain pulse crosses one cell per cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    chain_start |-> ##N_CELLS chain_end)
    else begin
      $error("chain_end did not follow chain_start after %0d cycles", N_CELLS);
      fail_cnt++;
    end

  // cluster halt is sticky
  assert property (@(posedge clk) disable iff (!rst_n) halt_q |=> halt_q)
    else begin
      $error("halt_q fell before reset");
      fail_cnt++;
    end

endmodule

// ==== verification/tb_cpu_block.sv ====
module tb_cpu_block;
  import cpu_cluster_pkg::*;

  localparam int N_CELLS        = 4;
  localparam int OPS_PER_CELL   = 4;
  // cell 0 owns only protected words, none of its writes go out
  localparam int EXP_WRITES     = (N_CELLS - 1) * OPS_PER_CELL;
  // 16 read/write pairs at about 40 cycles worst case, plus reset and chain
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int SETTLE_CYCLES  = 20;
  localparam data_t FILL_KEY    = 16'h5a5a;

  logic  clk        = 1'b0;
  logic  rst_n      = 1'b0;
  data_t data_in    = '0;
  logic  read_dn    = 1'b0;
  logic  write_dn   = 1'b0;
  logic  rw_halt_in = 1'b0;
  addr_t addr_out;
  data_t data_out;
  logic  read_q;
  logic  write_q;
  logic  rw_halt_out;
  logic  halt_q;

  int cycle_cnt  = 0;
  int write_cnt  = 0;
  int err_cnt    = 0;
  // cycles left before the pending done pulse
  int resp_delay = 0;
  int hold_left  = 0;

  cpu_block i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_in    (data_in),
    .read_dn    (read_dn),
    .write_dn   (write_dn),
    .rw_halt_in (rw_halt_in),
    .addr_out   (addr_out),
    .data_out   (data_out),
    .read_q     (read_q),
    .write_q    (write_q),
    .rw_halt_out(rw_halt_out),
    .halt_q     (halt_q)
  );

  bind cpu_block cpu_block_assertions #(
    .N_CELLS      (N_CELLS),
    .PROTECTED_TOP(PROTECTED_TOP)
  ) i_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr_out   (addr_out),
    .data_out   (data_out),
    .read_q     (read_q),
    .write_q    (write_q),
    .read_dn    (read_dn),
    .write_dn   (write_dn),
    .rw_halt_in (rw_halt_in),
    .rw_halt_out(rw_halt_out),
    .halt_q     (halt_q),
    .grant      (grant),
    .chain_start(chain_start),
    .chain_end  (chain_end)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // external memory contents
  function automatic data_t mem_word(addr_t addr);
    return data_t'(addr) ^ FILL_KEY;
  endfunction

  // memory model, done pulse 1 to 4 cycles into each request
  always @(negedge clk) begin
    read_dn  = 1'b0;
    write_dn = 1'b0;
    if (!rst_n) begin
      resp_delay = 0;
    end else if (read_q || write_q) begin
      if (resp_delay == 0) begin
        resp_delay = 1 + int'($urandom % 4);
      end
      resp_delay = resp_delay - 1;
      if (resp_delay == 0) begin
        if (read_q) begin
          data_in = mem_word(addr_out);
          read_dn = 1'b1;
        end else begin
          write_dn  = 1'b1;
          write_cnt = write_cnt + 1;
        end
      end
    end
  end

  // short random hold-off bursts
  always @(negedge clk) begin
    if (!rst_n) begin
      hold_left  = 0;
      rw_halt_in = 1'b0;
    end else if (hold_left > 0) begin
      hold_left  = hold_left - 1;
      rw_halt_in = 1'b1;
    end else if ($urandom % 8 == 0) begin
      hold_left  = int'($urandom % 3);
      rw_halt_in = 1'b1;
    end else begin
      rw_halt_in = 1'b0;
    end
  end

  task automatic wait_for_halt();
    while (!halt_q && cycle_cnt < TIMEOUT_CYCLES) begin
      @(negedge clk);
    end
    if (!halt_q) begin
      $display("timeout: halt_q still low after %0d cycles", cycle_cnt);
      err_cnt = err_cnt + 1;
    end
  endtask

  task automatic check_write_count();
    if (write_cnt != EXP_WRITES) begin
      $display("error: write_cnt 0x%0h, expected 0x%0h", write_cnt, EXP_WRITES);
      err_cnt = err_cnt + 1;
    end
  endtask

  initial begin
    int assert_errs;
    void'($urandom(32'h8cd5));
    rst_n = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    wait_for_halt();
    if (halt_q) begin
      check_write_count();
      // idle tail, halt_q has to hold
      repeat (SETTLE_CYCLES) @(negedge clk);
    end
    assert_errs = i_dut.i_assertions.fail_cnt;
    $display("external writes %0d, testbench errors %0d, assertion errors %0d",
             write_cnt, err_cnt, assert_errs);
    if (err_cnt == 0 && assert_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
